//--- cache_bridge.sv
// bridge model: read/write acceptance, read latency pipeline, sram access and ordering checks
`timescale 1ns/1ps
`include "dcache_config.svh"

module cache_bridge (
    input  logic                                 clock,
    input  logic                                 reset,

    // read channel from the cache
    input  logic                                 rd_req,
    input  dcache_pkg::bridge_rd_t               rd,
    output logic                                 rd_rdy,
    output logic                                 ret_valid,
    output dcache_pkg::bridge_ret_t              ret,

    // write channel from the cache
    input  logic                                 wr_req,
    input  dcache_pkg::bridge_wr_t               wr,
    output logic                                 wr_rdy,

    // sram port
    output logic                                 sram_en,
    output logic                                 sram_we,
    output logic [3:0]                           sram_wstrb,
    output logic [$clog2(`DCACHE_SRAM_WORDS)-1:0] sram_index,
    output logic [31:0]                          sram_wdata,
    input  logic [31:0]                          sram_rdata
);
    import dcache_pkg::*;

    localparam int rd_lat = `DCACHE_RD_LATENCY;
    localparam int idx_w = $clog2(`DCACHE_SRAM_WORDS);
    localparam logic [rd_lat-1:0] ret_mask = rd_lat'(1) << (rd_lat - 1);

    // one flag per read in flight, bit 0 newest, top bit returns this cycle
    logic [rd_lat-1:0] rd_pipe;
    logic              rd_accept;
    logic              wr_accept;
    logic [31:0]       ret_data;

    assign rd_rdy = ~&rd_pipe;
    // a write may not pass a read still waiting for its sram data
    assign wr_rdy = ~|(rd_pipe & ~ret_mask);

    assign rd_accept = rd_req && rd_rdy;
    assign wr_accept = wr_req && wr_rdy;

    // sram read is issued at acceptance, writes land at their own acceptance edge
    assign sram_en = rd_accept || wr_accept;
    assign sram_we = wr_accept;
    assign sram_wstrb = wr.wr_wstrb;
    assign sram_wdata = wr.wr_data[31:0];
    assign sram_index = wr_accept ? wr.wr_addr[idx_w+1:2] : rd.rd_addr[idx_w+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe <= (rd_pipe << 1) | rd_lat'(rd_accept);
        end
    end

    generate
        if (rd_lat == 1) begin : g_ret_direct
            // sram output register already lines up with the return cycle
            assign ret_data = sram_rdata;
        end else begin : g_ret_delay
            logic [31:0] data_q [rd_lat-1];

            always_ff @(posedge clock) begin
                data_q[0] <= sram_rdata;
                for (int i = 1; i < rd_lat - 1; i++) begin
                    data_q[i] <= data_q[i-1];
                end
            end

            assign ret_data = data_q[rd_lat-2];
        end
    endgenerate

    assign ret_valid = rd_pipe[rd_lat-1];
    assign ret = '{ret_last: rd_pipe[rd_lat-1], ret_data: ret_data};

    // only single-word transfers are modelled
    type_is_word: assert property (
        @(posedge clock) disable iff (reset)
        (rd_req -> rd.rd_type == type_word) && (wr_req -> wr.wr_type == type_word)
    );

    sram_single_access: assert property (
        @(posedge clock) disable iff (reset)
        !(rd_accept && wr_accept)
    );

endmodule

//--- data_sram.sv
// word-wide synchronous ram with byte write strobes and registered read data
`timescale 1ns/1ps
`include "dcache_config.svh"

module data_sram #(
    parameter int depth = `DCACHE_SRAM_WORDS
) (
    input  logic                     clock,
    input  logic                     en,
    input  logic                     we,
    input  logic [3:0]               wstrb,
    input  logic [$clog2(depth)-1:0] index,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata
);

    // storage starts cleared
    logic [31:0] mem [depth] = '{default: '0};

    // byte lanes with strobe low keep their old contents
    always_ff @(posedge clock) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // read data holds until the next read
    always_ff @(posedge clock) begin
        if (en && !we) begin
            rdata <= mem[index];
        end
    end

endmodule

//--- dcache_bypass.sv
// bypass data cache: lsu to bridge request forwarding, read tracking fsm, protocol assertions
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_bypass (
    input  logic                    clock,
    input  logic                    reset,

    // load/store unit side
    input  logic                    valid,
    input  dcache_pkg::lsu_req_t    req,
    output logic                    ready,
    output logic                    rvalid,
    output logic [31:0]             rdata,

    // bridge read channel
    output logic                    rd_req,
    output dcache_pkg::bridge_rd_t  rd,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  dcache_pkg::bridge_ret_t ret,

    // bridge write channel
    output logic                    wr_req,
    output dcache_pkg::bridge_wr_t  wr,
    input  logic                    wr_rdy
);
    import dcache_pkg::*;

    localparam logic [1:0] state_reset = 2'd0;
    localparam logic [1:0] state_idle = 2'd1;
    localparam logic [1:0] state_receive = 2'd2;

    logic [1:0]                state;
    logic                      state_is_idle;
    logic                      state_is_receive;
    logic                      receive_finish;
    logic                      can_accept;
    logic                      is_read;
    logic                      is_write;
    logic                      accept;
    logic [`DCACHE_ADDR_W-1:0] word_addr;

    assign state_is_idle = (state == state_idle);
    assign state_is_receive = (state == state_receive);

    // the single-beat return closes the pending read
    assign receive_finish = state_is_receive && ret_valid && ret.ret_last;

    // a new request may overlap the cycle the pending read completes
    assign can_accept = state_is_idle || receive_finish;

    // cache ops never reach the bridge
    assign is_read = !req.cacop_en && (req.op == op_read);
    assign is_write = !req.cacop_en && (req.op == op_write);

    assign ready = can_accept &&
                   (req.cacop_en || (is_write && wr_rdy) || (is_read && rd_rdy));
    assign accept = valid && ready;

    assign rvalid = receive_finish;
    assign rdata = ret.ret_data;

    // bypass path only moves whole words
    assign word_addr = {req.addr[`DCACHE_ADDR_W-1:2], 2'b00};

    assign rd_req = can_accept && valid && is_read;
    assign rd = '{rd_type: type_word, rd_addr: word_addr};

    assign wr_req = can_accept && valid && is_write;
    assign wr = '{
        wr_type:  type_word,
        wr_addr:  word_addr,
        wr_wstrb: req.awstrb,
        wr_data:  {96'b0, req.wdata}
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_reset;
        end else begin
            case (state)
                state_idle: begin
                    if (accept && is_read) begin
                        state <= state_receive;
                    end
                end
                state_receive: begin
                    if (accept && is_read) begin
                        // next read goes out as this one returns
                        state <= state_receive;
                    end else if (receive_finish) begin
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // word reads come back as one beat, or the receive state never ends
    ret_single_beat: assert property (
        @(posedge clock) disable iff (reset)
        ret_valid |-> ret.ret_last
    );

    // the bridge only answers a read this cache has outstanding
    ret_in_receive: assert property (
        @(posedge clock) disable iff (reset)
        ret_valid |-> state_is_receive
    );

endmodule

//--- dcache_config.svh
// dcache subsystem defines: address width, sram depth, bridge read latency
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width on the lsu and bridge ports
`define DCACHE_ADDR_W 32

// backing sram depth in 32-bit words
// index comes from address bits 9..2, higher bits ignored
`define DCACHE_SRAM_WORDS 256

// cycles from read acceptance to the return beat
// legal range is 1 to 4
`define DCACHE_RD_LATENCY 2

`endif

//--- dcache_pkg.sv
// dcache subsystem package: lsu request, bridge read/write/return structs, transfer type and op codes
`include "dcache_config.svh"

package dcache_pkg;

    // transfer type for a single 32-bit word
    localparam logic [2:0] type_word = 3'd2;

    // lsu op encoding
    localparam logic op_read = 1'b0;
    localparam logic op_write = 1'b1;

    // load/store unit request, held stable while valid waits for ready
    typedef struct packed {
        logic                      op;
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic                      uncached;
        logic [3:0]                awstrb;
        logic [31:0]               wdata;
        logic                      cacop_en;
        // cache op code bits 4..3
        logic [1:0]                cacop_code;
        logic [`DCACHE_ADDR_W-1:0] cacop_addr;
    } lsu_req_t;

    // read request toward the bridge
    typedef struct packed {
        logic [2:0]                rd_type;
        logic [`DCACHE_ADDR_W-1:0] rd_addr;
    } bridge_rd_t;

    // write request toward the bridge, a full line wide
    typedef struct packed {
        logic [2:0]                wr_type;
        logic [`DCACHE_ADDR_W-1:0] wr_addr;
        logic [3:0]                wr_wstrb;
        // only the low word is meaningful for word transfers
        logic [127:0]              wr_data;
    } bridge_wr_t;

    // read return beat from the bridge
    typedef struct packed {
        logic        ret_last;
        logic [31:0] ret_data;
    } bridge_ret_t;

endpackage

//--- dcache_stim.txt
// columns: op cacop_en addr awstrb wdata expected, all hex; op 0 read, 1 write
// expected is the read data for reads, or the word left in memory after a write
0 0 00000010 0 00000000 00000000
0 0 00000024 0 00000000 00000000
1 0 00000010 f 11223344 11223344
0 0 00000010 0 00000000 11223344
1 0 00000020 f a5a5a5a5 a5a5a5a5
0 0 00000020 0 00000000 a5a5a5a5
1 0 00000020 3 0000beef a5a5beef
0 0 00000020 0 00000000 a5a5beef
1 0 00000020 8 7f000000 7fa5beef
0 0 00000020 0 00000000 7fa5beef
1 0 00000020 4 00c30000 7fc3beef
0 0 00000020 0 00000000 7fc3beef
1 0 00000030 f cafef00d cafef00d
1 0 00000034 f 0badc0de 0badc0de
1 0 00000038 f 12345678 12345678
0 1 00000030 0 00000000 00000000
1 1 00000034 f ffffffff 00000000
0 0 00000030 0 00000000 cafef00d
0 0 00000034 0 00000000 0badc0de
0 0 00000038 0 00000000 12345678
0 0 00000010 0 00000000 11223344
0 0 00000020 0 00000000 7fc3beef
1 0 00000100 f deadbeef deadbeef
1 0 00000104 f 01020304 01020304
0 0 00000100 0 00000000 deadbeef
0 0 00000104 0 00000000 01020304
1 0 00000500 1 000000ff deadbeff
0 0 00000100 0 00000000 deadbeff
0 0 00000502 0 00000000 deadbeff
1 0 00000104 6 00aabb00 01aabb04
0 0 00000104 0 00000000 01aabb04
0 1 00000104 0 00000000 00000000
0 0 00000104 0 00000000 01aabb04
0 0 000003fc 0 00000000 00000000
1 0 000003fc f 89abcdef 89abcdef
0 0 000003fc 0 00000000 89abcdef
0 0 00000000 0 00000000 00000000
1 0 00000000 c 55660000 55660000
0 0 00000000 0 00000000 55660000
0 0 00000400 0 00000000 55660000
0 0 00000024 0 00000000 00000000

//--- dcache_subsys_top.sv
// dcache subsystem top: bypass cache, bridge model and data sram wiring
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_subsys_top (
    input  logic                 clock,
    input  logic                 reset,

    // load/store unit port
    input  logic                 valid,
    input  dcache_pkg::lsu_req_t req,
    output logic                 ready,
    output logic                 rvalid,
    output logic [31:0]          rdata
);
    import dcache_pkg::*;

    // cache to bridge
    logic        rd_req;
    bridge_rd_t  rd;
    logic        rd_rdy;
    logic        ret_valid;
    bridge_ret_t ret;
    logic        wr_req;
    bridge_wr_t  wr;
    logic        wr_rdy;

    // bridge to sram
    logic                                 sram_en;
    logic                                 sram_we;
    logic [3:0]                           sram_wstrb;
    logic [$clog2(`DCACHE_SRAM_WORDS)-1:0] sram_index;
    logic [31:0]                          sram_wdata;
    logic [31:0]                          sram_rdata;

    dcache_bypass u_dcache (
        .clock     (clock),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .ready     (ready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd        (rd),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret       (ret),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    cache_bridge u_bridge (
        .clock      (clock),
        .reset      (reset),
        .rd_req     (rd_req),
        .rd         (rd),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret        (ret),
        .wr_req     (wr_req),
        .wr         (wr),
        .wr_rdy     (wr_rdy),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_wstrb (sram_wstrb),
        .sram_index (sram_index),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    data_sram #(
        .depth (`DCACHE_SRAM_WORDS)
    ) u_sram (
        .clock (clock),
        .en    (sram_en),
        .we    (sram_we),
        .wstrb (sram_wstrb),
        .index (sram_index),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the dcache subsystem testbench with verilator and run it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_dcache_subsys \
    && ./obj_dir/Vtb_dcache_subsys \
    || { echo "dcache run ended with an error status"; exit 1; }

exit 0

//--- tb_clock_gen.sv
// testbench clock source with 40 ns period and a 4-cycle reset pulse
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // reset released on the fourth rising edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

//--- tb_dcache_subsys.sv
// dcache subsystem testbench: stimulus reader, lsu port driver, response monitor and timeout
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache_subsys;
    import dcache_pkg::*;

    localparam int rd_lat = `DCACHE_RD_LATENCY;

    typedef struct packed {
        dcache_pkg::lsu_req_t req;
        logic [31:0]          exp;
    } stim_t;

    // accepted request that has not yet reached its return cycle
    typedef struct packed {
        dcache_pkg::lsu_req_t req;
        logic [31:0]          exp;
        logic [31:0]          accept_cycle;
    } pending_t;

    logic        clock;
    logic        reset;
    logic        valid;
    lsu_req_t    req;
    logic        ready;
    logic        rvalid;
    logic [31:0] rdata;

    // expected read data, driven together with req
    logic [31:0] cur_exp;

    stim_t       stim_q[$];
    pending_t    pending[$];
    pending_t    head;
    logic        matched;
    logic        read_in_flight;
    logic [31:0] cycle_count;
    logic [31:0] timeout_limit;
    logic [31:0] lcg_state;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (reset)
    );

    dcache_subsys_top UUT (
        .clock  (clock),
        .reset  (reset),
        .valid  (valid),
        .req    (req),
        .ready  (ready),
        .rvalid (rvalid),
        .rdata  (rdata)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // only plain reads are answered, writes and cache ops are silent
    function automatic logic expects_return(input lsu_req_t r);
        return !r.cacop_en && (r.op == op_read);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_resp(input lsu_req_t r, input logic got_rvalid);
        if (got_rvalid !== expects_return(r)) begin
            fail_run($sformatf("[FAIL] %0t: op %0d cacop %0d at %h gave rvalid %0d, expected %0d",
                               $time, r.op, r.cacop_en, r.addr, got_rvalid,
                               expects_return(r)));
        end
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                               input logic [31:0] addr);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %0t: read of %h returned %h, expected %h",
                               $time, addr, got, exp));
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_cac;
        logic [31:0] f_addr;
        logic [31:0] f_strb;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        stim_t       s;
        fd = $fopen("dcache_stim.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file dcache_stim.txt");
        end else begin
            // comment and blank lines do not scan as six fields
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h",
                            f_op, f_cac, f_addr, f_strb, f_wdata, f_exp);
                if (n == 6) begin
                    s = '0;
                    s.req.op = f_op[0];
                    s.req.addr = f_addr;
                    s.req.awstrb = f_strb[3:0];
                    s.req.wdata = f_wdata;
                    s.req.cacop_en = f_cac[0];
                    s.req.cacop_addr = f_addr;
                    s.exp = f_exp;
                    stim_q.push_back(s);
                end
            end
            $fclose(fd);
        end
    endtask

    // response monitor, sampled on the same edges the driver uses
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                               timeout_limit));
        end else if (!reset) begin
            matched = 1'b0;
            if (pending.size() != 0 &&
                pending[0].accept_cycle + 32'(rd_lat) == cycle_count) begin
                head = pending.pop_front();
                matched = 1'b1;
                check_resp(head.req, rvalid);
                if (expects_return(head.req)) begin
                    check_rdata(rdata, head.exp, head.req.addr);
                end
            end
            read_in_flight = 1'b0;
            foreach (pending[i]) begin
                if (expects_return(pending[i].req)) begin
                    read_in_flight = 1'b1;
                end
            end
            if (rvalid && !matched) begin
                fail_run("rvalid came in a cycle where no read was due to return");
            end else if (valid && ready && read_in_flight) begin
                fail_run("a request was accepted while an earlier read was still in flight");
            end else if (valid && ready) begin
                pending.push_back('{req: req, exp: cur_exp, accept_cycle: cycle_count});
            end
        end
    end

    initial begin
        logic [1:0] gap;
        logic       prev_read;
        valid = 1'b0;
        req = '0;
        cur_exp = '0;
        cycle_count = '0;
        lcg_state = 32'h6f54;
        prev_read = 1'b0;
        timeout_limit = 32'hffff_ffff;
        load_stimulus();
        timeout_limit = 32'(stim_q.size() * (rd_lat + 8) + 20);

        // first edge lies inside the reset pulse, then wait for its release
        @(posedge clock);
        while (reset) begin
            @(posedge clock);
        end

        foreach (stim_q[i]) begin
            // a request right after a read goes out at once, overlapping the return
            if (prev_read) begin
                gap = 2'd0;
            end else begin
                lcg_state = lcg_step(lcg_state);
                gap = lcg_state[17:16];
            end
            if (gap != 2'd0) begin
                valid <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            valid <= 1'b1;
            req <= stim_q[i].req;
            cur_exp <= stim_q[i].exp;
            @(posedge clock);
            while (!ready) begin
                @(posedge clock);
            end
            prev_read = expects_return(stim_q[i].req);
        end
        valid <= 1'b0;

        // let the last requests reach their return cycle, then watch for a stray rvalid
        @(negedge clock);
        while (pending.size() != 0) begin
            @(negedge clock);
        end
        repeat (rd_lat + 2) begin
            @(negedge clock);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
dcache_pkg.sv
data_sram.sv
cache_bridge.sv
dcache_bypass.sv
dcache_subsys_top.sv
tb_clock_gen.sv
tb_dcache_subsys.sv
